//--- src/ucb_pkg.sv
package ucb_pkg;

   // Packet type codes in header bits 3:0
   localparam logic [3:0] ucb_read_nack = 4'b0000;
   localparam logic [3:0] ucb_read_ack  = 4'b0001;
   localparam logic [3:0] ucb_read_req  = 4'b0100;
   localparam logic [3:0] ucb_write_req = 4'b0101;
   localparam logic [3:0] ucb_int       = 4'b1000;

   localparam int ucb_reg_count    = 8;   // Local register file depth
   localparam int ucb_doorbell_idx = 7;   // Write here raises an interrupt

   // Request and ack header word with the high field first
   typedef struct packed {
      logic [9:0]  rsv;
      logic [39:0] addr;
      logic [2:0]  size;     // Carried but never interpreted
      logic [1:0]  buf_id;
      logic [4:0]  thr;
      logic [3:0]  pkt;
   } ucb_req_hdr_t;

   // Interrupt header word
   typedef struct packed {
      logic [33:0] rsv;
      logic [5:0]  vec;
      logic [5:0]  stat;
      logic [8:0]  dev;
      logic [4:0]  thr;
      logic [3:0]  pkt;      // Same place as in the request view
   } ucb_int_hdr_t;

   // One header word decoded by packet type
   typedef union packed {
      ucb_req_hdr_t req;
      ucb_int_hdr_t intr;
   } ucb_hdr_u;

   typedef struct packed {
      logic [63:0] data;     // Second word on the bus
      ucb_hdr_u    hdr;      // First word whose low beat goes first
   } ucb_pkt_t;

   // Queued request to the local unit
   typedef struct packed {
      logic        rd;
      logic        wr;
      logic [4:0]  thr;
      logic [1:0]  buf_id;
      logic [2:0]  size;
      logic [39:0] addr;
      logic [63:0] data;     // Write data unused by reads
   } ucb_req_t;

   typedef struct packed {
      logic        nack;
      logic [4:0]  thr;
      logic [1:0]  buf_id;
      logic [63:0] data;
   } ucb_ack_t;

   typedef struct packed {
      logic [4:0]  thr;
      logic [8:0]  dev;
      logic [5:0]  stat;
      logic [5:0]  vec;
   } ucb_intr_t;

endpackage

//--- src/ucb_bus_in.sv
module ucb_bus_in #(
   parameter int IOB_UCB_WIDTH = 16
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     iob_ucb_vld,
   input  logic [IOB_UCB_WIDTH-1:0] iob_ucb_data,
   output logic                     ucb_iob_stall,
   output logic                     in_vld,
   output ucb_pkg::ucb_pkt_t        in_pkt,
   input  logic                     in_ready
);

   localparam int BEATS = 128 / IOB_UCB_WIDTH;            // Beats per packet
   localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

   logic [CNT_W-1:0] beat_cnt;
   logic             pkt_full;    // Packet assembled and waiting for the core
   logic             beat_take;
   logic             last_beat;
   logic [127:0]     shift_q;

   assign beat_take = iob_ucb_vld & ~pkt_full;   // Bridge holds beats while stalled
   assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         beat_cnt <= '0;
         pkt_full <= 1'b0;
      end else begin
         if (beat_take) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
         end
         if (beat_take && last_beat) begin
            pkt_full <= 1'b1;
         end else if (in_ready) begin
            pkt_full <= 1'b0;    // Core took it
         end
      end
   end

   // New beat enters at the top, so the first beat ends up lowest
   always_ff @(posedge clk) begin
      if (beat_take) begin
         shift_q <= {iob_ucb_data, shift_q[127:IOB_UCB_WIDTH]};
      end
   end

   assign in_pkt        = shift_q;
   assign in_vld        = pkt_full;
   assign ucb_iob_stall = pkt_full;   // Hold the bridge until the transfer

endmodule

//--- src/ucb_flow.sv
module ucb_flow (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               in_vld,
   input  ucb_pkg::ucb_pkt_t  in_pkt,
   output logic               in_ready,
   output logic               req_vld,
   output ucb_pkg::ucb_req_t  req,
   input  logic               req_acpted,
   input  logic               ack_vld,
   input  ucb_pkg::ucb_ack_t  ack,
   output logic               ack_busy,
   input  logic               int_vld,
   input  ucb_pkg::ucb_intr_t intr,
   output logic               int_busy,
   output logic               out_wr,
   output ucb_pkg::ucb_pkt_t  out_pkt,
   output logic [1:0]         out_vec,    // One enable per 64-bit word
   input  logic               out_busy
);

   ucb_pkg::ucb_req_hdr_t in_hdr;
   logic                  is_rd;
   logic                  is_wr;
   logic                  wr_buf;
   logic                  rd_buf;
   logic [1:0]            buf_head;   // One-hot
   logic [1:0]            buf_tail;   // One-hot
   logic [1:0]            head_rot;
   logic [1:0]            tail_rot;
   logic                  buf_full;
   logic                  buf_empty;
   ucb_pkg::ucb_req_t     req_in;
   ucb_pkg::ucb_req_t     req_q [2];
   logic                  ack_buf_vld;
   logic                  int_buf_vld;
   logic                  int_last;   // Interrupt was served last
   logic                  ack_rd;
   logic                  int_rd;
   ucb_pkg::ucb_ack_t     ack_q;
   ucb_pkg::ucb_intr_t    int_q;

   assign in_hdr   = in_pkt.hdr.req;
   assign is_rd    = (in_hdr.pkt == ucb_pkg::ucb_read_req);
   assign is_wr    = (in_hdr.pkt == ucb_pkg::ucb_write_req);
   assign in_ready = ~buf_full | ~(is_rd | is_wr);   // Unknown types always drain
   assign wr_buf   = in_vld & in_ready & (is_rd | is_wr);
   assign rd_buf   = req_vld & req_acpted;
   assign head_rot = {buf_head[0], buf_head[1]};
   assign tail_rot = {buf_tail[0], buf_tail[1]};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         buf_head  <= 2'b01;
         buf_tail  <= 2'b01;
         buf_full  <= 1'b0;
         buf_empty <= 1'b1;
      end else begin
         if (rd_buf) buf_head <= head_rot;
         if (wr_buf) buf_tail <= tail_rot;
         if (wr_buf && !rd_buf) begin
            buf_empty <= 1'b0;
            buf_full  <= (tail_rot == buf_head);   // Tail caught the head
         end else if (rd_buf && !wr_buf) begin
            buf_full  <= 1'b0;
            buf_empty <= (head_rot == buf_tail);
         end
      end
   end

   assign req_in = '{rd: is_rd, wr: is_wr, thr: in_hdr.thr, buf_id: in_hdr.buf_id,
                     size: in_hdr.size, addr: in_hdr.addr, data: in_pkt.data};

   always_ff @(posedge clk) begin
      if (wr_buf && buf_tail[0]) req_q[0] <= req_in;
      if (wr_buf && buf_tail[1]) req_q[1] <= req_in;
   end

   assign req     = buf_head[0] ? req_q[0] : req_q[1];
   assign req_vld = ~buf_empty;

   // One-entry response buffers the unit fills only while not busy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_buf_vld <= 1'b0;
         int_buf_vld <= 1'b0;
         int_last    <= 1'b0;
      end else begin
         if (ack_vld) ack_buf_vld <= 1'b1;
         else if (ack_rd) ack_buf_vld <= 1'b0;
         if (int_vld) int_buf_vld <= 1'b1;
         else if (int_rd) int_buf_vld <= 1'b0;
         if (ack_rd || int_rd) int_last <= int_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (ack_vld) ack_q <= ack;
      if (int_vld) int_q <= intr;
   end

   assign ack_busy = ack_buf_vld;
   assign int_busy = int_buf_vld;

   // Round robin that alternates only when both wait
   assign ack_rd = ~out_busy & ack_buf_vld & (~int_buf_vld | int_last);
   assign int_rd = ~out_busy & int_buf_vld & (~ack_buf_vld | ~int_last);
   assign out_wr = ack_rd | int_rd;

   always_comb begin
      out_pkt = '0;
      out_vec = 2'b01;                         // Header word only
      if (ack_rd) begin
         out_pkt.data           = ack_q.data;
         out_pkt.hdr.req.pkt    = ack_q.nack ? ucb_pkg::ucb_read_nack : ucb_pkg::ucb_read_ack;
         out_pkt.hdr.req.thr    = ack_q.thr;
         out_pkt.hdr.req.buf_id = ack_q.buf_id;
         out_vec                = ack_q.nack ? 2'b01 : 2'b11;
      end else begin
         out_pkt.hdr.intr.pkt  = ucb_pkg::ucb_int;   // Interrupt view of the word
         out_pkt.hdr.intr.thr  = int_q.thr;
         out_pkt.hdr.intr.dev  = int_q.dev;
         out_pkt.hdr.intr.stat = int_q.stat;
         out_pkt.hdr.intr.vec  = int_q.vec;
      end
   end

endmodule

//--- src/ucb_reg_unit.sv
module ucb_reg_unit #(
   parameter logic [8:0] DEV_ID = 9'h01a
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               req_vld,
   input  ucb_pkg::ucb_req_t  req,
   output logic               req_acpted,
   output logic               ack_vld,
   output ucb_pkg::ucb_ack_t  ack,
   input  logic               ack_busy,
   output logic               int_vld,
   output ucb_pkg::ucb_intr_t intr,
   input  logic               int_busy
);

   logic [63:0] regs [ucb_pkg::ucb_reg_count];
   logic [2:0]  idx;
   logic        in_range;
   logic        is_db;      // Doorbell register hit
   logic        rd_ok;
   logic        db_ok;
   logic        take_rd;
   logic        take_wr;

   assign idx      = req.addr[5:3];
   assign in_range = ~|req.addr[39:6];
   assign is_db    = in_range & (idx == 3'(ucb_pkg::ucb_doorbell_idx));

   // Busy from the core lags our own pulse by a cycle
   assign rd_ok = ~ack_busy & ~ack_vld;
   assign db_ok = ~int_busy & ~int_vld;

   assign req_acpted = req_vld & (req.rd ? rd_ok : (~is_db | db_ok));
   assign take_rd    = req_acpted & req.rd;
   assign take_wr    = req_acpted & req.wr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_vld <= 1'b0;
         int_vld <= 1'b0;
         for (int i = 0; i < ucb_pkg::ucb_reg_count; i++) begin
            regs[i] <= '0;
         end
      end else begin
         ack_vld <= take_rd;              // Single-cycle pulses
         int_vld <= take_wr & is_db;
         if (take_wr && in_range) begin
            regs[idx] <= req.data;        // Out of range writes vanish
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_rd) begin
         ack.nack   <= ~in_range;
         ack.thr    <= req.thr;
         ack.buf_id <= req.buf_id;
         ack.data   <= in_range ? regs[idx] : '0;
      end
      if (take_wr && is_db) begin
         intr.thr  <= req.thr;
         intr.dev  <= DEV_ID;
         intr.stat <= '0;
         intr.vec  <= req.data[5:0];
      end
   end

endmodule

//--- src/ucb_bus_out.sv
module ucb_bus_out #(
   parameter int UCB_IOB_WIDTH = 8
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     out_wr,
   input  ucb_pkg::ucb_pkt_t        out_pkt,
   input  logic [1:0]               out_vec,
   output logic                     out_busy,
   output logic                     ucb_iob_vld,
   output logic [UCB_IOB_WIDTH-1:0] ucb_iob_data,
   input  logic                     iob_ucb_stall
);

   localparam int BEATS = 128 / UCB_IOB_WIDTH;   // Beats for a full packet
   localparam int HALF  = BEATS / 2;             // Beats per 64-bit word

   logic [127:0]     data_q;
   logic [BEATS-1:0] vec_q;     // Beats still to send with the current one lowest
   logic [BEATS-1:0] vec_in;
   logic             shift;

   // Word enables widen to beat enables
   assign vec_in = {{HALF{out_vec[1]}}, {HALF{out_vec[0]}}};

   assign out_busy = |vec_q;
   assign shift    = out_busy & ~iob_ucb_stall;   // Beat leaves only when not stalled

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vec_q <= '0;
      end else if (out_wr) begin
         vec_q <= vec_in;
      end else if (shift) begin
         vec_q <= vec_q >> 1;
      end
   end

   always_ff @(posedge clk) begin
      if (out_wr) begin
         data_q <= out_pkt;
      end else if (shift) begin
         data_q <= data_q >> UCB_IOB_WIDTH;
      end
   end

   // Beat stays on the bus through a stall
   assign ucb_iob_vld  = vec_q[0];
   assign ucb_iob_data = data_q[UCB_IOB_WIDTH-1:0];

endmodule

//--- src/ucb_top.sv
module ucb_top #(
   parameter int         IOB_UCB_WIDTH = 16,
   parameter int         UCB_IOB_WIDTH = 8,
   parameter logic [8:0] DEV_ID        = 9'h01a
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     iob_ucb_vld,
   input  logic [IOB_UCB_WIDTH-1:0] iob_ucb_data,
   output logic                     ucb_iob_stall,
   output logic                     ucb_iob_vld,
   output logic [UCB_IOB_WIDTH-1:0] ucb_iob_data,
   input  logic                     iob_ucb_stall
);

   logic               in_vld;       // Assembled packet to the core
   ucb_pkg::ucb_pkt_t  in_pkt;
   logic               in_ready;
   logic               req_vld;      // Queue head to the register unit
   ucb_pkg::ucb_req_t  req;
   logic               req_acpted;
   logic               ack_vld;
   ucb_pkg::ucb_ack_t  ack;
   logic               ack_busy;
   logic               int_vld;
   ucb_pkg::ucb_intr_t intr;
   logic               int_busy;
   logic               out_wr;       // Arbiter winner to the serializer
   ucb_pkg::ucb_pkt_t  out_pkt;
   logic [1:0]         out_vec;
   logic               out_busy;

   ucb_bus_in #(.IOB_UCB_WIDTH(IOB_UCB_WIDTH)) u_bus_in (
      .clk, .arst_n, .iob_ucb_vld, .iob_ucb_data, .ucb_iob_stall,
      .in_vld, .in_pkt, .in_ready
   );

   ucb_flow u_flow (
      .clk, .arst_n,
      .in_vld, .in_pkt, .in_ready,
      .req_vld, .req, .req_acpted,
      .ack_vld, .ack, .ack_busy,
      .int_vld, .intr, .int_busy,
      .out_wr, .out_pkt, .out_vec, .out_busy
   );

   ucb_reg_unit #(.DEV_ID(DEV_ID)) u_reg_unit (
      .clk, .arst_n,
      .req_vld, .req, .req_acpted,
      .ack_vld, .ack, .ack_busy,
      .int_vld, .intr, .int_busy
   );

   ucb_bus_out #(.UCB_IOB_WIDTH(UCB_IOB_WIDTH)) u_bus_out (
      .clk, .arst_n, .out_wr, .out_pkt, .out_vec, .out_busy,
      .ucb_iob_vld, .ucb_iob_data, .iob_ucb_stall
   );

endmodule

//--- sim/ucb_assertions.sv
module ucb_assertions (
   input logic              clk,
   input logic              arst_n,
   input logic              req_vld,
   input ucb_pkg::ucb_req_t req,
   input logic              req_acpted,
   input logic              wr_buf,
   input logic              buf_empty,
   input logic [1:0]        buf_head,
   input logic [1:0]        buf_tail,
   input logic              ack_vld,
   input logic              ack_busy,
   input logic              int_vld,
   input logic              int_busy,
   input logic              out_wr,
   input logic              out_busy
);

   int fail_cnt = 0;

   // Head of queue held until the unit takes it
   assert property (@(posedge clk) disable iff (!arst_n)
      req_vld && !req_acpted |=> req_vld && $stable(req))
      else begin
         fail_cnt++;
         $error("Request changed or dropped before acceptance");
      end

   // Tail on the head of a non-empty queue means full
   assert property (@(posedge clk) disable iff (!arst_n)
      wr_buf && !buf_empty |-> buf_tail != buf_head)
      else begin
         fail_cnt++;
         $error("Request queue written while full");
      end

   assert property (@(posedge clk) disable iff (!arst_n) !(ack_vld && ack_busy))
      else begin
         fail_cnt++;
         $error("Ack pulse while ack buffer busy");
      end

   assert property (@(posedge clk) disable iff (!arst_n) !(int_vld && int_busy))
      else begin
         fail_cnt++;
         $error("Interrupt pulse while interrupt buffer busy");
      end

   // Serializer takes the load and holds off the next one
   assert property (@(posedge clk) disable iff (!arst_n) out_wr |=> out_busy)
      else begin
         fail_cnt++;
         $error("Serializer not busy after a load");
      end

endmodule

bind ucb_flow ucb_assertions u_assert (.*);

//--- sim/ucb_checker.sv
module ucb_checker #(
   parameter int         IOB_UCB_WIDTH = 16,
   parameter int         UCB_IOB_WIDTH = 8,
   parameter logic [8:0] DEV_ID        = 9'h01a
) (
   input logic                     clk,
   input logic                     arst_n,
   input logic                     iob_ucb_vld,
   input logic [IOB_UCB_WIDTH-1:0] iob_ucb_data,
   input logic                     ucb_iob_stall,
   input logic                     ucb_iob_vld,
   input logic [UCB_IOB_WIDTH-1:0] ucb_iob_data,
   input logic                     iob_ucb_stall
);

   localparam int IN_BEATS = 128 / IOB_UCB_WIDTH;
   localparam int OUT_HALF = 64 / UCB_IOB_WIDTH;   // Beats per header word

   logic [63:0]  model [ucb_pkg::ucb_reg_count];   // Register file model
   logic [127:0] exp_ack [$];                      // Acks and nacks in arrival order
   logic [127:0] exp_int [$];
   string        name_ack [$];
   string        name_int [$];
   string        test_name;
   int           mismatches = 0;
   int           other_errs = 0;
   logic [127:0] in_shift;
   int           in_cnt = 0;
   logic [127:0] out_shift = '0;
   int           out_cnt = 0;
   bit           started = 0;   // First inbound beat seen
   int           cls;
   logic [127:0] exp_pkt;

   initial begin
      for (int i = 0; i < ucb_pkg::ucb_reg_count; i++) model[i] = '0;
   end

   // Returns class 0 for no response, 1 for an ack or nack and 2 for an interrupt
   // Model follows request order
   function automatic void expect_response(input logic [127:0] p, output int c,
                                           output logic [127:0] e);
      ucb_pkg::ucb_pkt_t pkt;
      logic              in_range;
      logic [2:0]        idx;
      pkt      = p;
      e        = '0;
      c        = 0;
      in_range = (pkt.hdr.req.addr[39:6] == '0);
      idx      = pkt.hdr.req.addr[5:3];
      if (pkt.hdr.req.pkt == ucb_pkg::ucb_read_req) begin
         c         = 1;
         e[3:0]    = in_range ? ucb_pkg::ucb_read_ack : ucb_pkg::ucb_read_nack;
         e[8:4]    = pkt.hdr.req.thr;
         e[10:9]   = pkt.hdr.req.buf_id;
         e[127:64] = in_range ? model[idx] : 64'h0;   // Not sent for a nack
      end else if (pkt.hdr.req.pkt == ucb_pkg::ucb_write_req && in_range) begin
         model[idx] = pkt.data;
         if (idx == 3'(ucb_pkg::ucb_doorbell_idx)) begin
            c       = 2;
            e[3:0]  = ucb_pkg::ucb_int;
            e[8:4]  = pkt.hdr.req.thr;
            e[17:9] = DEV_ID;
            e[29:24] = pkt.data[5:0];   // Vector with stat left zero
         end
      end
   endfunction

   task automatic check_out(input logic [127:0] got);
      logic [127:0] exp;
      logic [127:0] mask;
      string        name;
      exp = '0;
      name = "";
      if (got[3:0] == ucb_pkg::ucb_int && exp_int.size() != 0) begin
         exp  = exp_int.pop_front();
         name = name_int.pop_front();
      end else if (got[3:0] != ucb_pkg::ucb_int && exp_ack.size() != 0) begin
         exp  = exp_ack.pop_front();
         name = name_ack.pop_front();
      end
      mask = (exp[3:0] == ucb_pkg::ucb_read_ack) ? '1 : {64'h0, {64{1'b1}}};
      if (name == "") begin
         other_errs++;
         $display("Unexpected outbound packet with header %h", got[63:0]);
      end else if ((got & mask) !== (exp & mask)) begin
         mismatches++;
         $display("ERROR %s: expected %h actual %h", name, exp & mask, got & mask);
      end
   endtask

   // Sampled mid-cycle where both sides of each handshake are stable
   always @(negedge clk) begin
      if (arst_n && !started && (ucb_iob_vld || ucb_iob_stall)) begin
         other_errs++;
         $display("Outbound valid or inbound stall active before any stimulus");
      end
      if (arst_n && iob_ucb_vld) started = 1;
      if (arst_n && iob_ucb_vld && !ucb_iob_stall) begin   // Beat taken next edge
         in_shift = {iob_ucb_data, in_shift[127:IOB_UCB_WIDTH]};
         in_cnt++;
         if (in_cnt == IN_BEATS) begin
            in_cnt = 0;
            expect_response(in_shift, cls, exp_pkt);
            if (cls == 1) begin
               exp_ack.push_back(exp_pkt);
               name_ack.push_back(test_name);
            end else if (cls == 2) begin
               exp_int.push_back(exp_pkt);
               name_int.push_back(test_name);
            end
         end
      end
      if (arst_n && ucb_iob_vld && !iob_ucb_stall) begin
         out_shift[out_cnt*UCB_IOB_WIDTH +: UCB_IOB_WIDTH] = ucb_iob_data;
         out_cnt++;
         // Only a read ack carries its data word
         if ((out_cnt == OUT_HALF && out_shift[3:0] != ucb_pkg::ucb_read_ack) ||
             out_cnt == 2 * OUT_HALF) begin
            check_out(out_shift);
            out_cnt   = 0;
            out_shift = '0;
         end
      end
   end

   task automatic drain_wait();
      int cnt;
      cnt = 0;
      while ((exp_ack.size() != 0 || exp_int.size() != 0) && cnt < 5000) begin
         @(posedge clk);
         cnt++;
      end
      if (exp_ack.size() != 0 || exp_int.size() != 0) begin
         other_errs++;
         $display("Drain timeout with %0d acks and %0d interrupts missing",
                  exp_ack.size(), exp_int.size());
      end
      repeat (50) @(posedge clk);   // Window for stray packets
   endtask

endmodule

//--- sim/tb_ucb.sv
module tb_ucb;

   localparam int         IOB_UCB_WIDTH = 16;
   localparam int         UCB_IOB_WIDTH = 8;
   localparam logic [8:0] DEV_ID        = 9'h01a;
   localparam int         IN_BEATS      = 128 / IOB_UCB_WIDTH;

   logic                     clk;
   logic                     arst_n;
   logic                     iob_ucb_vld;
   logic [IOB_UCB_WIDTH-1:0] iob_ucb_data;
   logic                     ucb_iob_stall;
   logic                     ucb_iob_vld;
   logic [UCB_IOB_WIDTH-1:0] ucb_iob_data;
   logic                     iob_ucb_stall;
   logic [31:0]              stim_seed;
   logic [31:0]              stall_seed;
   logic                     rand_stall;   // Random outbound back-pressure on
   int                       timeouts;
   int                       total;

   ucb_top #(.IOB_UCB_WIDTH(IOB_UCB_WIDTH), .UCB_IOB_WIDTH(UCB_IOB_WIDTH), .DEV_ID(DEV_ID))
      uut (.*);

   ucb_checker #(.IOB_UCB_WIDTH(IOB_UCB_WIDTH), .UCB_IOB_WIDTH(UCB_IOB_WIDTH), .DEV_ID(DEV_ID))
      chk (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Roughly one cycle in four stalled
   always @(posedge clk) begin
      #1;
      stall_seed    = lcg_next(stall_seed);
      iob_ucb_stall = rand_stall & (stall_seed[31:30] == 2'b00);
   end

   function automatic logic [127:0] make_pkt(input logic [3:0] pkt, input logic [4:0] thr,
                                             input logic [1:0] buf_id, input logic [39:0] addr,
                                             input logic [63:0] data);
      return {data, 10'h0, addr, 3'd3, buf_id, thr, pkt};
   endfunction

   task automatic send_pkt(input logic [127:0] pkt);
      int wait_cnt;
      for (int b = 0; b < IN_BEATS; b++) begin
         iob_ucb_vld  = 1'b1;
         iob_ucb_data = pkt[b*IOB_UCB_WIDTH +: IOB_UCB_WIDTH];
         wait_cnt     = 0;
         while (ucb_iob_stall && wait_cnt < 200) begin
            @(posedge clk);
            #1;
            wait_cnt++;
         end
         if (ucb_iob_stall) begin
            timeouts++;
            $display("Timeout: inbound stall never released");
         end
         @(posedge clk);
         #1;
      end
      iob_ucb_vld = 1'b0;
   endtask

   initial begin
      logic [31:0] r1;
      logic [31:0] r2;
      logic [39:0] addr;
      clk           = 1'b0;
      arst_n        = 1'b0;
      iob_ucb_vld   = 1'b0;
      iob_ucb_data  = '0;
      iob_ucb_stall = 1'b0;
      rand_stall    = 1'b0;
      stim_seed     = 32'hdc668b09;
      stall_seed    = 32'hdc668b09;
      timeouts      = 0;
      chk.test_name = "reset";
      repeat (8) @(posedge clk);
      #1 arst_n = 1'b1;
      repeat (10) @(posedge clk);   // Idle window while the checker watches both outputs
      #1;
      chk.test_name = "write_read";
      send_pkt(make_pkt(ucb_pkg::ucb_write_req, 5'd3, 2'd1, 40'h10, 64'hdead_beef_0123_4567));
      send_pkt(make_pkt(ucb_pkg::ucb_read_req, 5'd3, 2'd1, 40'h10, 64'h0));
      chk.test_name = "out_of_range";
      send_pkt(make_pkt(ucb_pkg::ucb_read_req, 5'd9, 2'd2, 40'h40, 64'h0));
      send_pkt(make_pkt(ucb_pkg::ucb_write_req, 5'd9, 2'd2, 40'h50, 64'h1111));   // Low bits hit reg 2
      send_pkt(make_pkt(ucb_pkg::ucb_read_req, 5'd9, 2'd3, 40'h10, 64'h0));
      chk.test_name = "doorbell";
      send_pkt(make_pkt(ucb_pkg::ucb_write_req, 5'd17, 2'd0, 40'h38, 64'h2a5));
      chk.test_name = "unknown_type";
      send_pkt(make_pkt(4'h3, 5'd4, 2'd0, 40'h10, 64'h0));
      send_pkt(make_pkt(4'hf, 5'd4, 2'd0, 40'h18, 64'h0));
      send_pkt(make_pkt(ucb_pkg::ucb_read_req, 5'd4, 2'd1, 40'h10, 64'h0));
      chk.test_name = "random";
      rand_stall = 1'b1;
      repeat (200) begin
         stim_seed = lcg_next(stim_seed);
         r1        = stim_seed;
         stim_seed = lcg_next(stim_seed);
         r2        = stim_seed;
         addr      = {33'h0, (r1[3:0] == 4'h0), r1[10:8], 3'b000};   // 1 in 16 out of range
         send_pkt(make_pkt(r1[16] ? ucb_pkg::ucb_write_req : ucb_pkg::ucb_read_req,
                           r1[21:17], r1[23:22], addr, {r2, r1}));
      end
      chk.drain_wait();
      rand_stall = 1'b0;
      total = chk.mismatches + chk.other_errs + timeouts + uut.u_flow.u_assert.fail_cnt;
      $display("Mismatches %0d, other errors %0d, timeouts %0d, assertion failures %0d",
               chk.mismatches, chk.other_errs, timeouts, uut.u_flow.u_assert.fail_cnt);
      if (total == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- tb.f
src/ucb_pkg.sv
src/ucb_bus_in.sv
src/ucb_flow.sv
src/ucb_reg_unit.sv
src/ucb_bus_out.sv
src/ucb_top.sv
sim/ucb_assertions.sv
sim/ucb_checker.sv
sim/tb_ucb.sv
